// ==== testbench/cpu_tests.txt ====
# M addr data: memory image word, hex
# E addr data: expected store in program order, hex
M 010 08800080  # ldi r1, r0, 0x80
M 011 01080000  # ld r2, 0(r1)
M 012 01800081  # ld r3, 0x81(r0)
M 013 0A080080  # ldi r4, r1, 0x80
M 014 11200000  # st r2, 0(r4)
M 015 11800101  # st r3, 0x101(r0)
M 016 10A7FFFE  # st r1, -2(r4)
M 017 1A918000  # add r5, r2, r3
M 018 12A00002  # st r5, 2(r4)
M 019 23190000  # sub r6, r3, r2
M 01A 13200003
M 01B 53928000  # and r7, r2, r5
M 01C 13A00004
M 01D 5C0A8000  # or r8, r1, r5
M 01E 14200005
M 01F 6497FF88  # addi r9, r2, -0x78
M 020 14A00006
M 021 6D180F0F  # andi r10, r3, 0xf0f
M 022 15200007
M 023 758B0005  # ori r11, r1, 0x30005
M 024 15A00008
M 025 8E100000  # neg r12, r2
M 026 16200009
M 027 96980000  # not r13, r3
M 028 16A0000A
M 029 79180000  # mul r2, r3
M 02A C7000000  # mfhi r14
M 02B CF800000  # mflo r15
M 02C 1720000B
M 02D 17A0000C
M 02E 98000001  # br r0 zero, taken
M 02F 16A00011
M 030 99000001  # br r2 zero, not taken
M 031 16A00012
M 032 99080001  # br r2 nonzero, taken
M 033 16A00013
M 034 98080001  # br r0 nonzero, not taken
M 035 16A00014
M 036 9E900001  # br r13 positive, taken
M 037 16A00015
M 038 99900001  # br r3 positive, not taken
M 039 16A00016
M 03A 99980001  # br r3 negative, taken
M 03B 16A00017
M 03C 9E980001  # br r13 negative, not taken
M 03D 16A00018
M 03E D0000000  # nop
M 03F D8000000  # halt
M 040 16A0001F  # never reached
M 080 12345678
M 081 FFFFFFF9
E 100 12345678
E 101 FFFFFFF9
E 0FE 00000080
E 102 12345671
E 103 EDCBA981
E 104 12345670
E 105 123456F1
E 106 12345600
E 107 00000F09
E 108 00030085
E 109 EDCBA988
E 10A 00000006
E 10B FFFFFFFF
E 10C 8091A2B8
E 112 00000006
E 114 00000006
E 116 00000006
E 118 00000006

// ==== sim.f ====
common/isa_pkg.sv
common/ctrl_pkg.sv
datapath/register_file.sv
datapath/alu.sv
datapath/datapath.sv
control/control_unit.sv
verilog/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: multicycle_cpu

sources:
  - common/isa_pkg.sv
  - common/ctrl_pkg.sv
  - datapath/register_file.sv
  - datapath/alu.sv
  - datapath/datapath.sv
  - control/control_unit.sv
  - verilog/cpu_top.sv
  - target: simulation
    files:
      - testbench/cpu_props.sv
      - testbench/cpu_tb.sv

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

    localparam int aw = isa_pkg::addr_width;
    localparam int w = isa_pkg::word_width;
    localparam logic [aw-1:0] start_pc = 9'h010;  // program origin

    logic          clk;
    logic          reset;
    logic [w-1:0]  mem_rdata;
    logic [aw-1:0] mem_addr;
    logic [w-1:0]  mem_wdata;
    logic          mem_read;
    logic          mem_write;
    logic          halted;

    logic [w-1:0]  mem [2**aw];
    logic [aw-1:0] exp_addr [$];   // expected stores, oldest first
    logic [w-1:0]  exp_data [$];
    int            image_words = 0;
    int            cycle_limit = 1000000;
    int            cycles = 0;
    bit            first_read_seen = 1'b0;

    cpu_top #(
        .reset_pc (start_pc)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .halted    (halted)
    );

    // combinational read, write on the clock edge
    assign mem_rdata = mem[mem_addr];

    always @(posedge clk) begin
        if (mem_write) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    task automatic stop_run;
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [w-1:0] actual,
                               input logic [w-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_run();
        end
    endtask

    // opcode 31 decodes as nop if it is ever fetched
    function automatic logic [w-1:0] fill_word(input int a);
        return {5'h1f, 9'h000, a[8:0], a[8:0]};
    endfunction

    task automatic load_tests;
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [7:0]       kind;
        logic [31:0]      addr;
        logic [31:0]      data;
        fd = $fopen("testbench/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/cpu_tests.txt");
            stop_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h", kind, addr, data);
                if (n == 3 && kind == "M") begin
                    mem[addr[aw-1:0]] = data;
                    image_words++;
                end else if (n == 3 && kind == "E") begin
                    exp_addr.push_back(addr[aw-1:0]);
                    exp_data.push_back(data);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles without the CPU halting", cycles);
            stop_run();
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset) begin
            first_read_seen = 1'b0;
        end else if (uut.u_ctrl.u_props.fail_count != 0) begin
            $display("a controller assertion failed near cycle %0d", cycles);
            stop_run();
        end else if (mem_write && exp_addr.size() == 0) begin
            $display("unexpected store to address 0x%h, no expected store left", mem_addr);
            stop_run();
        end else if (mem_write) begin
            check_value("mem_addr", w'(mem_addr), w'(exp_addr[0]));
            check_value("mem_wdata", mem_wdata, exp_data[0]);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end else if (mem_read && !first_read_seen) begin
            first_read_seen = 1'b1;
            check_value("mem_addr", w'(mem_addr), w'(start_pc));  // first fetch
        end
    end

    initial begin
        reset = 1'b1;
        for (int a = 0; a < 2**aw; a++) begin
            mem[a] = fill_word(a);
        end
        load_tests();
        cycle_limit = 8 * image_words + 16 + 100;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);   // no store may follow halt
        if (exp_addr.size() != 0) begin
            $display("CPU halted with %0d expected stores never seen", exp_addr.size());
            stop_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== testbench/cpu_props.sv ====
`timescale 1ns/10ps

module cpu_props (
    input logic             clk,
    input logic             reset,
    input ctrl_pkg::state_t state,
    input logic             mem_read,
    input logic             mem_write,
    input logic             halted
);

    int fail_count = 0;    // polled by the testbench

    // memory port carries one transfer per cycle
    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high in the same cycle");
            fail_count++;
        end

    no_write_in_reset: assert property (@(posedge clk)
        reset |-> !mem_write)
        else begin
            $error("mem_write high while reset is asserted");
            fail_count++;
        end

    halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted dropped without reset");
            fail_count++;
        end

    state_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state))
        else begin
            $error("controller state is unknown");
            fail_count++;
        end

endmodule

bind control_unit cpu_props u_props (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halted    (halted)
);

// ==== verilog/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top #(
    parameter logic [isa_pkg::addr_width-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [isa_pkg::word_width-1:0] mem_rdata,
    output logic [isa_pkg::addr_width-1:0] mem_addr,
    output logic [isa_pkg::word_width-1:0] mem_wdata,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic                           halted
);

    ctrl_pkg::bus_src_t bus_sel;
    ctrl_pkg::alu_op_t  alu_op;
    ctrl_pkg::reg_sel_t reg_sel;
    isa_pkg::opcode_t   opcode;
    logic               con_ff;
    logic               r_in;
    logic               pc_enable;
    logic               pc_increment;
    logic               ir_enable;
    logic               y_enable;
    logic               z_enable;
    logic               mar_enable;
    logic               mdr_enable;
    logic               hi_enable;
    logic               lo_enable;
    logic               con_enable;

    // strobes share names on both sides
    control_unit u_ctrl (.*);

    datapath #(
        .reset_pc (reset_pc)
    ) u_dp (.*);

endmodule

// ==== control/control_unit.sv ====
`timescale 1ns/10ps

module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  isa_pkg::opcode_t   opcode,
    input  logic               con_ff,
    output ctrl_pkg::bus_src_t bus_sel,
    output ctrl_pkg::alu_op_t  alu_op,
    output ctrl_pkg::reg_sel_t reg_sel,
    output logic               r_in,
    output logic               pc_enable,
    output logic               pc_increment,
    output logic               ir_enable,
    output logic               y_enable,
    output logic               z_enable,
    output logic               mar_enable,
    output logic               mdr_enable,
    output logic               hi_enable,
    output logic               lo_enable,
    output logic               con_enable,
    output logic               mem_read,
    output logic               mem_write,
    output logic               halted
);

    ctrl_pkg::state_t  state;
    ctrl_pkg::state_t  next_state;
    ctrl_pkg::alu_op_t decoded_op;

    // ALU function for the current instruction
    always_comb begin
        case (opcode)
            isa_pkg::op_sub:                   decoded_op = ctrl_pkg::alu_sub;
            isa_pkg::op_and, isa_pkg::op_andi: decoded_op = ctrl_pkg::alu_and;
            isa_pkg::op_or, isa_pkg::op_ori:   decoded_op = ctrl_pkg::alu_or;
            isa_pkg::op_neg:                   decoded_op = ctrl_pkg::alu_neg;
            isa_pkg::op_not:                   decoded_op = ctrl_pkg::alu_not;
            isa_pkg::op_mul:                   decoded_op = ctrl_pkg::alu_mul;
            default:                           decoded_op = ctrl_pkg::alu_add;  // also addresses
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ctrl_pkg::fetch0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ctrl_pkg::fetch0: next_state = ctrl_pkg::fetch1;
            ctrl_pkg::fetch1: next_state = ctrl_pkg::fetch2;
            ctrl_pkg::fetch2: begin
                case (opcode)
                    isa_pkg::op_ld:   next_state = ctrl_pkg::ld3;
                    isa_pkg::op_ldi:  next_state = ctrl_pkg::ldi3;
                    isa_pkg::op_st:   next_state = ctrl_pkg::st3;
                    isa_pkg::op_add, isa_pkg::op_sub,
                    isa_pkg::op_and, isa_pkg::op_or: next_state = ctrl_pkg::alu3;
                    isa_pkg::op_addi, isa_pkg::op_andi,
                    isa_pkg::op_ori:  next_state = ctrl_pkg::imm3;
                    isa_pkg::op_neg, isa_pkg::op_not: next_state = ctrl_pkg::un3;
                    isa_pkg::op_mul:  next_state = ctrl_pkg::mul3;
                    isa_pkg::op_mfhi: next_state = ctrl_pkg::mfhi3;
                    isa_pkg::op_mflo: next_state = ctrl_pkg::mflo3;
                    isa_pkg::op_br:   next_state = ctrl_pkg::br3;
                    isa_pkg::op_halt: next_state = ctrl_pkg::halt_s;
                    default:          next_state = ctrl_pkg::nop3;  // nop, unused codes
                endcase
            end
            ctrl_pkg::ld3:    next_state = ctrl_pkg::ld4;
            ctrl_pkg::ld4:    next_state = ctrl_pkg::ld5;
            ctrl_pkg::ld5:    next_state = ctrl_pkg::ld6;
            ctrl_pkg::ld6:    next_state = ctrl_pkg::ld7;
            ctrl_pkg::ldi3:   next_state = ctrl_pkg::ldi4;
            ctrl_pkg::ldi4:   next_state = ctrl_pkg::ldi5;
            ctrl_pkg::st3:    next_state = ctrl_pkg::st4;
            ctrl_pkg::st4:    next_state = ctrl_pkg::st5;
            ctrl_pkg::st5:    next_state = ctrl_pkg::st6;
            ctrl_pkg::st6:    next_state = ctrl_pkg::st7;
            ctrl_pkg::alu3:   next_state = ctrl_pkg::alu4;
            ctrl_pkg::alu4:   next_state = ctrl_pkg::alu5;
            ctrl_pkg::imm3:   next_state = ctrl_pkg::imm4;
            ctrl_pkg::imm4:   next_state = ctrl_pkg::imm5;
            ctrl_pkg::un3:    next_state = ctrl_pkg::un4;
            ctrl_pkg::mul3:   next_state = ctrl_pkg::mul4;
            ctrl_pkg::mul4:   next_state = ctrl_pkg::mul5;
            ctrl_pkg::mul5:   next_state = ctrl_pkg::mul6;
            ctrl_pkg::br3:    next_state = ctrl_pkg::br4;
            ctrl_pkg::br4:    next_state = ctrl_pkg::br5;
            ctrl_pkg::br5:    next_state = ctrl_pkg::br6;
            ctrl_pkg::halt_s: next_state = ctrl_pkg::halt_s;  // only reset leaves
            default:          next_state = ctrl_pkg::fetch0;  // last state of each instruction
        endcase
    end

    // per-state strobes
    always_comb begin
        bus_sel      = ctrl_pkg::bus_none;
        alu_op       = ctrl_pkg::alu_pass_b;
        reg_sel      = ctrl_pkg::sel_ra;
        r_in         = 1'b0;
        pc_enable    = 1'b0;
        pc_increment = 1'b0;
        ir_enable    = 1'b0;
        y_enable     = 1'b0;
        z_enable     = 1'b0;
        mar_enable   = 1'b0;
        mdr_enable   = 1'b0;
        hi_enable    = 1'b0;
        lo_enable    = 1'b0;
        con_enable   = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        halted       = 1'b0;
        case (state)
            ctrl_pkg::fetch0: begin
                bus_sel      = ctrl_pkg::bus_pc;
                mar_enable   = 1'b1;
                pc_increment = 1'b1;
            end
            ctrl_pkg::fetch1, ctrl_pkg::ld6: begin
                mem_read   = 1'b1;
                mdr_enable = 1'b1;
            end
            ctrl_pkg::fetch2: begin
                bus_sel   = ctrl_pkg::bus_mdr;
                ir_enable = 1'b1;
            end
            ctrl_pkg::ld3, ctrl_pkg::ldi3, ctrl_pkg::st3: begin
                bus_sel  = ctrl_pkg::bus_reg_base;
                reg_sel  = ctrl_pkg::sel_rb;
                y_enable = 1'b1;
            end
            ctrl_pkg::alu3, ctrl_pkg::imm3: begin
                bus_sel  = ctrl_pkg::bus_reg;
                reg_sel  = ctrl_pkg::sel_rb;
                y_enable = 1'b1;
            end
            ctrl_pkg::mul3: begin
                bus_sel  = ctrl_pkg::bus_reg;  // ra into Y
                y_enable = 1'b1;
            end
            ctrl_pkg::ld4, ctrl_pkg::ldi4, ctrl_pkg::st4, ctrl_pkg::imm4, ctrl_pkg::br5: begin
                bus_sel  = ctrl_pkg::bus_imm;
                alu_op   = decoded_op;
                z_enable = 1'b1;
            end
            ctrl_pkg::alu4: begin
                bus_sel  = ctrl_pkg::bus_reg;
                reg_sel  = ctrl_pkg::sel_rc;
                alu_op   = decoded_op;
                z_enable = 1'b1;
            end
            ctrl_pkg::un3, ctrl_pkg::mul4: begin
                bus_sel  = ctrl_pkg::bus_reg;
                reg_sel  = ctrl_pkg::sel_rb;
                alu_op   = decoded_op;
                z_enable = 1'b1;
            end
            ctrl_pkg::ld5, ctrl_pkg::st5: begin
                bus_sel    = ctrl_pkg::bus_zlo;
                mar_enable = 1'b1;
            end
            ctrl_pkg::ldi5, ctrl_pkg::alu5, ctrl_pkg::imm5, ctrl_pkg::un4: begin
                bus_sel = ctrl_pkg::bus_zlo;
                r_in    = 1'b1;
            end
            ctrl_pkg::ld7: begin
                bus_sel = ctrl_pkg::bus_mdr;
                r_in    = 1'b1;
            end
            ctrl_pkg::st6: begin
                bus_sel    = ctrl_pkg::bus_reg;  // ra into MDR, mem_read low
                mdr_enable = 1'b1;
            end
            ctrl_pkg::st7: mem_write = 1'b1;
            ctrl_pkg::mul5: begin
                bus_sel   = ctrl_pkg::bus_zlo;
                lo_enable = 1'b1;
            end
            ctrl_pkg::mul6: begin
                bus_sel   = ctrl_pkg::bus_zhi;
                hi_enable = 1'b1;
            end
            ctrl_pkg::mfhi3: begin
                bus_sel = ctrl_pkg::bus_hi;
                r_in    = 1'b1;
            end
            ctrl_pkg::mflo3: begin
                bus_sel = ctrl_pkg::bus_lo;
                r_in    = 1'b1;
            end
            ctrl_pkg::br3: begin
                bus_sel    = ctrl_pkg::bus_reg;  // ra tested against c2
                con_enable = 1'b1;
            end
            ctrl_pkg::br4: begin
                bus_sel  = ctrl_pkg::bus_pc;
                y_enable = 1'b1;
            end
            ctrl_pkg::br6: begin
                bus_sel   = ctrl_pkg::bus_zlo;
                pc_enable = con_ff;              // taken only if condition held
            end
            ctrl_pkg::halt_s: halted = 1'b1;
            default: ;                           // nop3 idles
        endcase
    end

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/10ps

module datapath #(
    parameter logic [isa_pkg::addr_width-1:0] reset_pc = '0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  ctrl_pkg::bus_src_t             bus_sel,
    input  ctrl_pkg::alu_op_t              alu_op,
    input  ctrl_pkg::reg_sel_t             reg_sel,
    input  logic                           r_in,
    input  logic                           pc_enable,
    input  logic                           pc_increment,
    input  logic                           ir_enable,
    input  logic                           y_enable,
    input  logic                           z_enable,
    input  logic                           mar_enable,
    input  logic                           mdr_enable,
    input  logic                           hi_enable,
    input  logic                           lo_enable,
    input  logic                           con_enable,
    input  logic                           mem_read,
    input  logic [isa_pkg::word_width-1:0] mem_rdata,
    output logic [isa_pkg::addr_width-1:0] mem_addr,
    output logic [isa_pkg::word_width-1:0] mem_wdata,
    output isa_pkg::opcode_t               opcode,
    output logic                           con_ff
);

    localparam int w = isa_pkg::word_width;
    localparam int aw = isa_pkg::addr_width;
    localparam int c_width = isa_pkg::c_hi - isa_pkg::c_lo + 1;

    logic [aw-1:0]  pc;
    logic [aw-1:0]  mar;
    logic [w-1:0]   ir;
    logic [w-1:0]   mdr;
    logic [w-1:0]   y;
    logic [2*w-1:0] z;
    logic [w-1:0]   hi;
    logic [w-1:0]   lo;
    logic [w-1:0]   bus;
    logic [w-1:0]   rd_data;
    logic [w-1:0]   imm;
    logic [2*w-1:0] alu_result;
    logic           cond_met;

    assign imm = {{(w - c_width){ir[isa_pkg::c_hi]}}, ir[isa_pkg::c_hi:isa_pkg::c_lo]};

    always_comb begin
        case (bus_sel)
            ctrl_pkg::bus_reg, ctrl_pkg::bus_reg_base: bus = rd_data;
            ctrl_pkg::bus_pc:  bus = {{(w - aw){1'b0}}, pc};
            ctrl_pkg::bus_mdr: bus = mdr;
            ctrl_pkg::bus_zlo: bus = z[w-1:0];
            ctrl_pkg::bus_zhi: bus = z[2*w-1:w];
            ctrl_pkg::bus_hi:  bus = hi;
            ctrl_pkg::bus_lo:  bus = lo;
            ctrl_pkg::bus_imm: bus = imm;
            default:           bus = '0;
        endcase
    end

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .reg_sel   (reg_sel),
        .ir_regs   (ir[isa_pkg::ra_hi:isa_pkg::rc_lo]),
        .r_in      (r_in),
        .bus_in    (bus),
        .base_mode (bus_sel == ctrl_pkg::bus_reg_base),
        .rd_data   (rd_data)
    );

    alu u_alu (
        .a      (y),
        .b      (bus),
        .op     (alu_op),
        .result (alu_result)
    );

    // ra is on the bus while con_enable is high
    always_comb begin
        case (isa_pkg::cond_t'(ir[isa_pkg::c2_hi:isa_pkg::c2_lo]))
            isa_pkg::cond_zero:     cond_met = (bus == '0);
            isa_pkg::cond_nonzero:  cond_met = (bus != '0);
            isa_pkg::cond_positive: cond_met = !bus[w-1] && (bus != '0);
            default:                cond_met = bus[w-1];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= reset_pc;
            ir     <= '0;
            con_ff <= 1'b0;
        end else begin
            if (pc_enable) begin
                pc <= bus[aw-1:0];        // branch target
            end else if (pc_increment) begin
                pc <= pc + 1'b1;
            end
            if (ir_enable) ir <= bus;
            if (con_enable) con_ff <= cond_met;
        end
    end

    always_ff @(posedge clk) begin
        if (mar_enable) mar <= bus[aw-1:0];
        if (mdr_enable) mdr <= mem_read ? mem_rdata : bus;
        if (y_enable) y <= bus;
        if (z_enable) z <= alu_result;
        if (hi_enable) hi <= bus;
        if (lo_enable) lo <= bus;
    end

    // decode in fetch2 needs the word before IR holds it
    assign opcode = isa_pkg::opcode_t'(ir_enable ? mdr[isa_pkg::opcode_hi:isa_pkg::opcode_lo]
                                                 : ir[isa_pkg::opcode_hi:isa_pkg::opcode_lo]);

    assign mem_addr  = mar;
    assign mem_wdata = mdr;

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic [isa_pkg::word_width-1:0]   a,
    input  logic [isa_pkg::word_width-1:0]   b,
    input  ctrl_pkg::alu_op_t                op,
    output logic [2*isa_pkg::word_width-1:0] result
);

    localparam int w = isa_pkg::word_width;

    logic signed [2*w-1:0] product;

    // both operands sign-extended to the full width first
    assign product = $signed(a) * $signed(b);

    always_comb begin
        case (op)
            ctrl_pkg::alu_add: result = {{w{1'b0}}, a + b};
            ctrl_pkg::alu_sub: result = {{w{1'b0}}, a - b};
            ctrl_pkg::alu_and: result = {{w{1'b0}}, a & b};
            ctrl_pkg::alu_or:  result = {{w{1'b0}}, a | b};
            ctrl_pkg::alu_neg: result = {{w{1'b0}}, -b};
            ctrl_pkg::alu_not: result = {{w{1'b0}}, ~b};
            ctrl_pkg::alu_mul: result = product;       // HI:LO
            default:           result = {{w{1'b0}}, b};
        endcase
    end

endmodule

// ==== datapath/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                           clk,
    input  logic                           reset,
    input  ctrl_pkg::reg_sel_t             reg_sel,
    input  logic [11:0]                    ir_regs,   // {ra, rb, rc}
    input  logic                           r_in,
    input  logic [isa_pkg::word_width-1:0] bus_in,
    input  logic                           base_mode,
    output logic [isa_pkg::word_width-1:0] rd_data
);

    logic [isa_pkg::word_width-1:0] regs [16];
    logic [3:0]                     idx;

    always_comb begin
        case (reg_sel)
            ctrl_pkg::sel_rb: idx = ir_regs[7:4];
            ctrl_pkg::sel_rc: idx = ir_regs[3:0];
            default:          idx = ir_regs[11:8];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (r_in) begin
            regs[idx] <= bus_in;
        end
    end

    // R0 means "no base" for address arithmetic
    assign rd_data = (base_mode && idx == 4'd0) ? '0 : regs[idx];

endmodule

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

    // one state per clock cycle
    typedef enum logic [5:0] {
        fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        st3, st4, st5, st6, st7,
        alu3, alu4, alu5,           // add, sub, and, or
        imm3, imm4, imm5,           // addi, andi, ori
        un3, un4,                   // neg, not
        mul3, mul4, mul5, mul6,
        mfhi3, mflo3,
        br3, br4, br5, br6,
        nop3,
        halt_s
    } state_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_neg,
        alu_not,
        alu_mul,
        alu_pass_b
    } alu_op_t;

    // what drives the internal bus
    typedef enum logic [3:0] {
        bus_none,
        bus_reg,
        bus_reg_base,               // register, R0 reads as zero
        bus_pc,
        bus_mdr,
        bus_zlo,
        bus_zhi,
        bus_hi,
        bus_lo,
        bus_imm
    } bus_src_t;

    typedef enum logic [1:0] {
        sel_ra,
        sel_rb,
        sel_rc
    } reg_sel_t;

endpackage

// ==== common/isa_pkg.sv ====
package isa_pkg;

    localparam int word_width = 32;
    localparam int addr_width = 9;    // word address into external memory

    // instruction word fields
    localparam int opcode_hi = 31;
    localparam int opcode_lo = 27;
    localparam int ra_hi = 26;
    localparam int ra_lo = 23;
    localparam int rb_hi = 22;
    localparam int rb_lo = 19;
    localparam int rc_hi = 18;
    localparam int rc_lo = 15;
    localparam int c_hi = 18;         // immediate, sign-extended
    localparam int c_lo = 0;
    localparam int c2_hi = 20;        // branch condition, overlaps rb
    localparam int c2_lo = 19;

    typedef enum logic [4:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd10,
        op_or   = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_mul  = 5'd15,
        op_neg  = 5'd17,
        op_not  = 5'd18,
        op_br   = 5'd19,
        op_mfhi = 5'd24,
        op_mflo = 5'd25,
        op_nop  = 5'd26,
        op_halt = 5'd27
    } opcode_t;

    typedef enum logic [1:0] {
        cond_zero     = 2'd0,
        cond_nonzero  = 2'd1,
        cond_positive = 2'd2,
        cond_negative = 2'd3
    } cond_t;

endpackage
